// ==== Makefile ====
# Verilator build and run of the data cache testbench

VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only -Wall --timing
PASS_TEXT ?= Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the run passes only if the pass line shows up in the output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== sim/dcache_tb.sv ====
// the model covers one read and one write port, random traffic uses seed 42 over small pools
`timescale 1ns/1ns
`default_nettype none

`include "dcache_defines.svh"

module dcache_tb
  import dcache_pkg::*;
();

  localparam int BUDGET_CYCLES = 4 + 16 + 8 + 4 + 16 + 40 + 2000;
  localparam longint WATCHDOG_NS = BUDGET_CYCLES * 2 * 100;

  logic                         clock = 1'b0;
  logic                         reset;
  logic                         rd_en;
  logic [`DCACHE_IDX_BITS-1:0]  rd_idx;
  logic [`DCACHE_TAG_BITS-1:0]  rd_tag;
  logic [`DCACHE_DATA_BITS-1:0] rd_data;
  logic                         rd_hit;
  logic                         rd_miss;
  logic                         wr_valid;
  wr_op_e                       wr_op;
  logic [`DCACHE_IDX_BITS-1:0]  wr_idx;
  logic [`DCACHE_TAG_BITS-1:0]  wr_tag;
  logic [`DCACHE_DATA_BITS-1:0] wr_data;
  logic                         wr_ready;
  logic                         wb_valid;
  logic [`DCACHE_IDX_BITS-1:0]  wb_idx;
  logic [`DCACHE_TAG_BITS-1:0]  wb_tag;
  logic [`DCACHE_DATA_BITS-1:0] wb_data;
  logic                         wb_ready;

  // reference state
  logic [`DCACHE_TAG_BITS-1:0]  m_tag   [`DCACHE_NUM_SETS][`DCACHE_NUM_WAYS];
  logic [`DCACHE_DATA_BITS-1:0] m_data  [`DCACHE_NUM_SETS][`DCACHE_NUM_WAYS];
  logic                         m_valid [`DCACHE_NUM_SETS][`DCACHE_NUM_WAYS];
  logic                         m_dirty [`DCACHE_NUM_SETS][`DCACHE_NUM_WAYS];
  logic [2:0]                   m_tree  [`DCACHE_NUM_SETS];
  // idx, tag, data of each expected writeback
  logic [76:0]                  wbq [$];

  integer seed = 42;
  integer errors = 0;
  integer checks = 0;
  integer wb_pops = 0;

  dcache_top i_dcache_top (.*);

  always #50 clock = ~clock;

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("mismatch at %0t ns: %s expected %0h actual %0h", $time, name, expected, actual);
    end
  endtask

  // root, then the node of the touched half, point away from the way
  function automatic logic [2:0] tree_after_touch(input logic [2:0] bits, input logic [1:0] way);
    logic [2:0] nb;
    nb = bits;
    nb[0] = (way < 2'd2);
    case (way)
      2'd0: nb[1] = 1'b1;
      2'd1: nb[1] = 1'b0;
      2'd2: nb[2] = 1'b1;
      default: nb[2] = 1'b0;
    endcase
    return nb;
  endfunction

  function automatic logic [1:0] tree_victim(input logic [2:0] bits);
    if (!bits[0]) begin
      return bits[1] ? 2'd1 : 2'd0;
    end
    return bits[2] ? 2'd3 : 2'd2;
  endfunction

  task automatic find_way(input logic [2:0] idx, input logic [9:0] tag,
                          output logic hit, output logic [1:0] way);
    hit = 1'b0;
    way = 2'd0;
    for (int w = 0; w < `DCACHE_NUM_WAYS; w++) begin
      if (m_valid[idx][w] && m_tag[idx][w] == tag) begin
        hit = 1'b1;
        way = 2'(w);
      end
    end
  endtask

  task automatic clear_model();
    for (int s = 0; s < `DCACHE_NUM_SETS; s++) begin
      m_tree[s] = 3'd0;
      for (int w = 0; w < `DCACHE_NUM_WAYS; w++) begin
        m_valid[s][w] = 1'b0;
        m_dirty[s][w] = 1'b0;
      end
    end
    wbq.delete();
  endtask

  // drive one cycle, check at the falling edge, then advance the model
  task automatic run_cycle(input logic re, input logic [2:0] ri, input logic [9:0] rt,
                           input logic wv, input logic wo, input logic [2:0] wi,
                           input logic [9:0] wt, input logic [63:0] wd, input logic wbr);
    logic       accept;
    logic       rhit;
    logic [1:0] rway;
    logic       whit;
    logic [1:0] wway;
    logic       fwd;
    logic       exp_hit;
    logic       exp_wb;
    @(posedge clock);
    rd_en    <= re;
    rd_idx   <= ri;
    rd_tag   <= rt;
    wr_valid <= wv;
    wr_op    <= wo ? WR_STORE : WR_FILL;
    wr_idx   <= wi;
    wr_tag   <= wt;
    wr_data  <= wd;
    wb_ready <= wbr;
    @(negedge clock);
    exp_wb = (wbq.size() != 0);
    accept = wv && (wbq.size() < `DCACHE_WB_DEPTH);
    check_value("wr_ready", wbq.size() < `DCACHE_WB_DEPTH, wr_ready);
    check_value("wb_valid", exp_wb, wb_valid);
    if (exp_wb) begin
      check_value("wb_idx", wbq[0][76:74], wb_idx);
      check_value("wb_tag", wbq[0][73:64], wb_tag);
      check_value("wb_data", wbq[0][63:0], wb_data);
    end
    find_way(ri, rt, rhit, rway);
    fwd = re && accept && (wi == ri) && (wt == rt);
    exp_hit = fwd || rhit;
    if (re) begin
      check_value("rd_hit", exp_hit, rd_hit);
      check_value("rd_miss", !exp_hit, rd_miss);
      if (exp_hit) begin
        check_value("rd_data", fwd ? wd : m_data[ri][rway], rd_data);
      end
    end else begin
      check_value("rd_miss", 1'b0, rd_miss);
    end
    // transfers seen on the writeback port
    if (wb_valid === 1'b1 && wbr) begin
      wb_pops++;
    end
    if (exp_wb && wbr) begin
      wbq.delete(0);
    end
    if (accept) begin
      find_way(wi, wt, whit, wway);
      if (!whit) begin
        wway = tree_victim(m_tree[wi]);
        if (m_valid[wi][wway] && m_dirty[wi][wway]) begin
          wbq.push_back({wi, m_tag[wi][wway], m_data[wi][wway]});
        end
      end
      m_dirty[wi][wway] = whit ? (m_dirty[wi][wway] | wo) : wo;
      m_valid[wi][wway] = 1'b1;
      m_tag[wi][wway]   = wt;
      m_data[wi][wway]  = wd;
      m_tree[wi] = tree_after_touch(m_tree[wi], wway);
    end
    // read touch lands on top of the write touch
    if (re && rhit) begin
      m_tree[ri] = tree_after_touch(m_tree[ri], rway);
    end
  endtask

  task automatic report_test(input int num, input string name, input int err_start);
    $display("test %0d %s finished with %0d errors", num, name, errors - err_start);
  endtask

  task automatic drain_queue(input int limit);
    int n;
    n = 0;
    while (wb_valid === 1'b1 && n < limit) begin
      run_cycle(1'b0, 3'd0, 10'd0, 1'b0, 1'b0, 3'd0, 10'd0, 64'd0, 1'b1);
      n++;
    end
    if (wb_valid !== 1'b0) begin
      errors++;
      $display("writeback queue did not drain within %0d cycles", limit);
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests finished");
    $display("Finished with errors");
    $finish;
  end

  initial begin
    int err_start;
    int pops_start;
    logic [63:0] d;
    logic re;
    logic wv;
    logic wo;
    logic wbr;
    logic [2:0] ri;
    logic [2:0] wi;
    logic [9:0] rt;
    logic [9:0] wt;
    reset    <= 1'b1;
    rd_en    <= 1'b0;
    rd_idx   <= '0;
    rd_tag   <= '0;
    wr_valid <= 1'b0;
    wr_op    <= WR_FILL;
    wr_idx   <= '0;
    wr_tag   <= '0;
    wr_data  <= '0;
    wb_ready <= 1'b0;
    clear_model();
    repeat (4) @(posedge clock);
    reset <= 1'b0;

    err_start = errors;
    for (int i = 0; i < 16; i++) begin
      ri = 3'($random(seed));
      rt = 10'($random(seed));
      run_cycle(1'b1, ri, rt, 1'b0, 1'b0, 3'd0, 10'd0, 64'd0, 1'b1);
      check_value("rd_miss", 1'b1, rd_miss);
    end
    report_test(1, "reset state", err_start);

    err_start = errors;
    d = {$random(seed), $random(seed)};
    run_cycle(1'b0, 3'd0, 10'd0, 1'b1, 1'b0, 3'd1, 10'd5, d, 1'b1);
    run_cycle(1'b1, 3'd1, 10'd5, 1'b0, 1'b0, 3'd0, 10'd0, 64'd0, 1'b1);
    check_value("rd_hit", 1'b1, rd_hit);
    check_value("rd_data", d, rd_data);
    run_cycle(1'b1, 3'd1, 10'd6, 1'b0, 1'b0, 3'd0, 10'd0, 64'd0, 1'b1);
    check_value("rd_miss", 1'b1, rd_miss);
    report_test(2, "fill then read", err_start);

    err_start = errors;
    d = {$random(seed), $random(seed)};
    run_cycle(1'b1, 3'd2, 10'd9, 1'b1, 1'b1, 3'd2, 10'd9, d, 1'b1);
    check_value("rd_hit", 1'b1, rd_hit);
    check_value("rd_data", d, rd_data);
    run_cycle(1'b1, 3'd2, 10'd9, 1'b0, 1'b0, 3'd0, 10'd0, 64'd0, 1'b1);
    check_value("rd_data", d, rd_data);
    report_test(3, "forwarding", err_start);

    // even writes store, odd writes fill; victims go 0, 2, 1, 3, 0, 2, 1
    err_start = errors;
    pops_start = wb_pops;
    for (int i = 0; i < 7; i++) begin
      d = {$random(seed), $random(seed)};
      run_cycle(1'b0, 3'd0, 10'd0, 1'b1, (i % 2 == 0), 3'd6, 10'd300 + 10'(i), d, 1'b1);
      if (i == 5) begin
        check_value("wb_tag", 10'd300, wb_tag);
      end
    end
    run_cycle(1'b0, 3'd0, 10'd0, 1'b0, 1'b0, 3'd0, 10'd0, 64'd0, 1'b1);
    check_value("wb_tag", 10'd302, wb_tag);
    repeat (2) run_cycle(1'b0, 3'd0, 10'd0, 1'b0, 1'b0, 3'd0, 10'd0, 64'd0, 1'b1);
    check_value("writeback count", 2, wb_pops - pops_start);
    report_test(4, "replacement", err_start);

    err_start = errors;
    drain_queue(8);
    pops_start = wb_pops;
    for (int i = 0; i < 8; i++) begin
      d = {$random(seed), $random(seed)};
      run_cycle(1'b0, 3'd0, 10'd0, 1'b1, 1'b1, 3'd3, 10'd400 + 10'(i), d, 1'b0);
    end
    run_cycle(1'b0, 3'd0, 10'd0, 1'b1, 1'b1, 3'd3, 10'd408, 64'd0, 1'b0);
    check_value("wr_ready", 1'b0, wr_ready);
    drain_queue(8);
    check_value("writeback count", 4, wb_pops - pops_start);
    report_test(5, "back-pressure", err_start);

    err_start = errors;
    for (int i = 0; i < 2000; i++) begin
      re  = 1'($random(seed));
      ri  = 3'd4 + 3'($random(seed) & 1);
      rt  = 10'd500 + 10'($random(seed) & 7);
      wv  = 1'($random(seed));
      wo  = 1'($random(seed));
      wi  = 3'd4 + 3'($random(seed) & 1);
      wt  = 10'd500 + 10'($random(seed) & 7);
      wbr = 1'($random(seed));
      d   = {$random(seed), $random(seed)};
      run_cycle(re, ri, rt, wv, wo, wi, wt, d, wbr);
    end
    report_test(6, "random mix", err_start);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/cachemem.sv ====
// one read and one write per cycle, reads never stall and a read miss is only flagged
`timescale 1ns/1ns
`default_nettype none

`include "dcache_defines.svh"

module cachemem
  import dcache_pkg::*;
(
  input  wire logic                         clock,
  input  wire logic                         reset,

  input  wire logic                         rd_en,
  input  wire logic [`DCACHE_IDX_BITS-1:0]  rd_idx,
  input  wire logic [`DCACHE_TAG_BITS-1:0]  rd_tag,
  output logic      [`DCACHE_DATA_BITS-1:0] rd_data,
  output logic                              rd_hit,
  output logic                              rd_miss,

  input  wire logic                         wr_valid,
  input  wire wr_op_e                       wr_op,
  input  wire logic [`DCACHE_IDX_BITS-1:0]  wr_idx,
  input  wire logic [`DCACHE_TAG_BITS-1:0]  wr_tag,
  input  wire logic [`DCACHE_DATA_BITS-1:0] wr_data,
  output logic                              wr_ready,

  evict_if.source                           evict
);

  localparam int WAY_BITS = $clog2(`DCACHE_NUM_WAYS);

  cache_line_t [`DCACHE_NUM_WAYS-1:0] sets [`DCACHE_NUM_SETS];
  logic [2:0]                         tree [`DCACHE_NUM_SETS];

  logic                rd_lookup_hit;
  logic [WAY_BITS-1:0] rd_lookup_way;
  logic                wr_lookup_hit;
  logic [WAY_BITS-1:0] wr_lookup_way;
  logic [WAY_BITS-1:0] wr_victim_way;
  logic [WAY_BITS-1:0] wr_way;
  logic [2:0]          wr_tree_next;
  logic [2:0]          rd_tree_base;
  logic [2:0]          rd_tree_next;
  logic                wr_accept;
  logic                rd_forward;
  logic                rd_touch;
  cache_line_t         wr_old_line;
  cache_line_t         wr_new_line;

  // a full writeback queue stalls every write
  assign wr_ready  = evict.ready;
  assign wr_accept = wr_valid & evict.ready;

  tag_match #(.WAYS(`DCACHE_NUM_WAYS)) i_rd_match (
    .ways (sets[rd_idx]),
    .tag  (rd_tag),
    .hit  (rd_lookup_hit),
    .way  (rd_lookup_way)
  );

  tag_match #(.WAYS(`DCACHE_NUM_WAYS)) i_wr_match (
    .ways (sets[wr_idx]),
    .tag  (wr_tag),
    .hit  (wr_lookup_hit),
    .way  (wr_lookup_way)
  );

  // write touches first
  plru_tree i_wr_plru (
    .bits       (tree[wr_idx]),
    .touch_way  (wr_way),
    .next_bits  (wr_tree_next),
    .victim_way (wr_victim_way)
  );

  assign wr_way = wr_lookup_hit ? wr_lookup_way : wr_victim_way;

  // read touch sits on top of the write touch when both hit one set
  assign rd_tree_base = (wr_accept && (wr_idx == rd_idx)) ? wr_tree_next : tree[rd_idx];

  plru_tree i_rd_plru (
    .bits       (rd_tree_base),
    .touch_way  (rd_lookup_way),
    .next_bits  (rd_tree_next),
    .victim_way ()
  );

  // same-cycle write to the same line wins over the stored copy
  assign rd_forward = rd_en & wr_accept & (wr_idx == rd_idx) & (wr_tag == rd_tag);
  assign rd_hit     = rd_forward | (rd_en & rd_lookup_hit);
  assign rd_miss    = rd_en & ~rd_hit;
  assign rd_data    = rd_forward ? wr_data : sets[rd_idx][rd_lookup_way].data;
  assign rd_touch   = rd_en & rd_lookup_hit;

  // hit way or replacement way
  assign wr_old_line = sets[wr_idx][wr_way];

  always_comb begin
    wr_new_line.data  = wr_data;
    wr_new_line.tag   = wr_tag;
    wr_new_line.valid = 1'b1;
    // a hit keeps an earlier dirty mark
    wr_new_line.dirty = (wr_op == WR_STORE) | (wr_lookup_hit & wr_old_line.dirty);
  end

  // only dirty victims go to memory
  assign evict.valid = wr_accept & ~wr_lookup_hit & wr_old_line.valid & wr_old_line.dirty;
  assign evict.idx   = wr_idx;
  assign evict.line  = wr_old_line;

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int s = 0; s < `DCACHE_NUM_SETS; s++) begin
        tree[s] <= '0;
        for (int w = 0; w < `DCACHE_NUM_WAYS; w++) begin
          sets[s][w].valid <= 1'b0;
          sets[s][w].dirty <= 1'b0;
        end
      end
    end else begin
      if (wr_accept) begin
        sets[wr_idx][wr_way] <= wr_new_line;
        tree[wr_idx]         <= wr_tree_next;
      end
      // later assignment so the read touch wins on a shared set
      if (rd_touch) begin
        tree[rd_idx] <= rd_tree_next;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/dcache_defines.svh ====
// the pseudo-LRU tree is built for exactly 4 ways and index plus tag must cover 13 address bits
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// geometry of the 32-line cache
`define DCACHE_NUM_WAYS 4
`define DCACHE_NUM_SETS 8

// address split
`define DCACHE_IDX_BITS 3
`define DCACHE_TAG_BITS 10

// one 64-bit word per line
`define DCACHE_DATA_BITS 64

// dirty victims waiting for memory
`define DCACHE_WB_DEPTH 4

`endif

// ==== source/dcache_pkg.sv ====
// line layout is data, tag, valid, dirty from msb down and is 76 bits wide
`default_nettype none

`include "dcache_defines.svh"

package dcache_pkg;

  // one cache line with its state bits
  typedef struct packed {
    logic [`DCACHE_DATA_BITS-1:0] data;
    logic [`DCACHE_TAG_BITS-1:0]  tag;
    logic                         valid;
    logic                         dirty;
  } cache_line_t;

  // fill leaves the line clean, store marks it dirty
  typedef enum logic {
    WR_FILL  = 1'b0,
    WR_STORE = 1'b1
  } wr_op_e;

endpackage

`default_nettype wire

// ==== source/dcache_top.sv ====
// writes stall whenever the writeback queue is full and read misses are only flagged
`timescale 1ns/1ns
`default_nettype none

`include "dcache_defines.svh"

module dcache_top
  import dcache_pkg::*;
(
  input  wire logic                         clock,
  input  wire logic                         reset,

  // read port
  input  wire logic                         rd_en,
  input  wire logic [`DCACHE_IDX_BITS-1:0]  rd_idx,
  input  wire logic [`DCACHE_TAG_BITS-1:0]  rd_tag,
  output logic      [`DCACHE_DATA_BITS-1:0] rd_data,
  output logic                              rd_hit,
  output logic                              rd_miss,

  // write port
  input  wire logic                         wr_valid,
  input  wire wr_op_e                       wr_op,
  input  wire logic [`DCACHE_IDX_BITS-1:0]  wr_idx,
  input  wire logic [`DCACHE_TAG_BITS-1:0]  wr_tag,
  input  wire logic [`DCACHE_DATA_BITS-1:0] wr_data,
  output logic                              wr_ready,

  // writeback to memory
  output logic                              wb_valid,
  output logic      [`DCACHE_IDX_BITS-1:0]  wb_idx,
  output logic      [`DCACHE_TAG_BITS-1:0]  wb_tag,
  output logic      [`DCACHE_DATA_BITS-1:0] wb_data,
  input  wire logic                         wb_ready
);

  evict_if i_evict ();

  cachemem i_cachemem (
    .clock    (clock),
    .reset    (reset),
    .rd_en    (rd_en),
    .rd_idx   (rd_idx),
    .rd_tag   (rd_tag),
    .rd_data  (rd_data),
    .rd_hit   (rd_hit),
    .rd_miss  (rd_miss),
    .wr_valid (wr_valid),
    .wr_op    (wr_op),
    .wr_idx   (wr_idx),
    .wr_tag   (wr_tag),
    .wr_data  (wr_data),
    .wr_ready (wr_ready),
    .evict    (i_evict.source)
  );

  writeback_queue #(.DEPTH(`DCACHE_WB_DEPTH)) i_writeback_queue (
    .clock    (clock),
    .reset    (reset),
    .evict    (i_evict.sink),
    .wb_valid (wb_valid),
    .wb_idx   (wb_idx),
    .wb_tag   (wb_tag),
    .wb_data  (wb_data),
    .wb_ready (wb_ready)
  );

endmodule

`default_nettype wire

// ==== source/evict_if.sv ====
// carries one evicted line per valid and ready edge and the source only offers dirty lines
`timescale 1ns/1ns
`default_nettype none

`include "dcache_defines.svh"

interface evict_if
  import dcache_pkg::*;
();

  logic                        valid;
  logic [`DCACHE_IDX_BITS-1:0] idx;
  cache_line_t                 line;
  logic                        ready;

  // cache memory side
  modport source (output valid, idx, line, input ready);

  // writeback queue side
  modport sink (input valid, idx, line, output ready);

endinterface

`default_nettype wire

// ==== source/plru_tree.sv ====
// purely combinational 4-way tree and the victim ignores whether ways are valid
`timescale 1ns/1ns
`default_nettype none

module plru_tree (
  input  wire logic [2:0] bits,
  input  wire logic [1:0] touch_way,
  output logic      [2:0] next_bits,
  output logic      [1:0] victim_way
);

  // bit 0 is the root, bit 1 covers ways 0 and 1, bit 2 covers ways 2 and 3
  // a 1 sends the victim to the right half

  // touch points every node on the path away from the way
  always_comb begin
    next_bits = bits;

    // root away from the touched half
    next_bits[0] = ~touch_way[1];

    // only the leaf node on the touched side moves
    if (touch_way[1]) begin
      next_bits[2] = ~touch_way[0];
    end else begin
      next_bits[1] = ~touch_way[0];
    end
  end

  // walk from the root to the victim
  always_comb begin
    victim_way[1] = bits[0];

    if (bits[0]) begin
      victim_way[0] = bits[2];
    end else begin
      victim_way[0] = bits[1];
    end
  end

  // from all zeros, fill and touch in a loop gives ways 0, 2, 1, 3

endmodule

`default_nettype wire

// ==== source/tag_match.sv ====
// assumes at most one valid way of a set holds a given tag
`timescale 1ns/1ns
`default_nettype none

`include "dcache_defines.svh"

module tag_match
  import dcache_pkg::*;
#(
  parameter int WAYS = 4
) (
  input  wire cache_line_t [WAYS-1:0]        ways,
  input  wire logic [`DCACHE_TAG_BITS-1:0]   tag,
  output logic                               hit,
  output logic [$clog2(WAYS)-1:0]            way
);

  localparam int WAY_BITS = $clog2(WAYS);

  logic [WAYS-1:0] match;

  // cam style compare across the set
  always_comb begin
    for (int i = 0; i < WAYS; i++) begin
      match[i] = ways[i].valid && (ways[i].tag == tag);
    end
  end

  assign hit = |match;

  // one-hot to binary
  always_comb begin
    way = '0;
    for (int i = 0; i < WAYS; i++) begin
      if (match[i]) begin
        way = way | WAY_BITS'(i);
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/writeback_queue.sv ====
// DEPTH must be at least 2 and a push is never taken while full
`timescale 1ns/1ns
`default_nettype none

`include "dcache_defines.svh"

module writeback_queue
  import dcache_pkg::*;
#(
  parameter int DEPTH = 4
) (
  input  wire logic                         clock,
  input  wire logic                         reset,

  evict_if.sink                             evict,

  output logic                              wb_valid,
  output logic      [`DCACHE_IDX_BITS-1:0]  wb_idx,
  output logic      [`DCACHE_TAG_BITS-1:0]  wb_tag,
  output logic      [`DCACHE_DATA_BITS-1:0] wb_data,
  input  wire logic                         wb_ready
);

  localparam int PTR_BITS = $clog2(DEPTH);
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  logic [`DCACHE_IDX_BITS-1:0] idx_mem  [DEPTH];
  cache_line_t                 line_mem [DEPTH];
  logic [PTR_BITS-1:0]         wr_ptr;
  logic [PTR_BITS-1:0]         rd_ptr;
  logic [CNT_BITS-1:0]         count;
  logic                        push;
  logic                        pop;

  function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
    return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign evict.ready = (count != CNT_BITS'(DEPTH));
  assign wb_valid    = (count != '0);

  assign push = evict.valid & evict.ready;
  assign pop  = wb_valid & wb_ready;

  // head entry stays put until popped
  assign wb_idx  = idx_mem[rd_ptr];
  assign wb_tag  = line_mem[rd_ptr].tag;
  assign wb_data = line_mem[rd_ptr].data;

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      count <= count + CNT_BITS'(push) - CNT_BITS'(pop);
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      idx_mem[wr_ptr]  <= evict.idx;
      line_mem[wr_ptr] <= evict.line;
    end
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+source
source/dcache_pkg.sv
source/evict_if.sv
source/tag_match.sv
source/plru_tree.sv
source/cachemem.sv
source/writeback_queue.sv
source/dcache_top.sv
sim/dcache_tb.sv
